// ==== build.f ====
+incdir+verilog
+incdir+tb
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_decode.sv
verilog/ex_div.sv
verilog/ex_writeback.sv
verilog/ex_stage.sv
tb/ex_tb.sv

// ==== tb/ex_tb_ref.svh ====
`ifndef EX_TB_REF_SVH
`define EX_TB_REF_SVH

// integer op by func3, alt picks sub or sra
function automatic ex_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                          input ex_pkg::word_t x, input ex_pkg::word_t y);
    logic [4:0] sh;
    sh = y[4:0];
    case (f3)
        `F3_ADD_SUB: alu_ref = alt ? x - y : x + y;
        `F3_SLL:     alu_ref = x << sh;
        `F3_SLT:     alu_ref = {31'b0, $signed(x) < $signed(y)};
        `F3_SLTU:    alu_ref = {31'b0, x < y};
        `F3_XOR:     alu_ref = x ^ y;
        `F3_SR: begin
            if (alt)
                alu_ref = $signed(x) >>> sh;
            else
                alu_ref = x >> sh;
        end
        `F3_OR:      alu_ref = x | y;
        default:     alu_ref = x & y;
    endcase
endfunction

function automatic ex_pkg::word_t div_ref(input logic [2:0] f3,
                                          input ex_pkg::word_t x, input ex_pkg::word_t y);
    int sx;
    int sy;
    logic ovf;
    sx = x;
    sy = y;
    ovf = (x == 32'h8000_0000) && (y == 32'hffff_ffff);
    if (y == '0)
        div_ref = f3[1] ? x : '1;  // rem keeps the dividend
    else if (ovf && f3 == `F3_DIV)
        div_ref = x;
    else if (ovf && f3 == `F3_REM)
        div_ref = '0;
    else begin
        case (f3)
            `F3_DIV:  div_ref = sx / sy;
            `F3_DIVU: div_ref = x / y;
            `F3_REM:  div_ref = sx % sy;
            default:  div_ref = x % y;
        endcase
    end
endfunction

// expected write-back and jump for one instruction
function automatic void ref_exec(input ex_pkg::word_t ins, input ex_pkg::word_t pc,
                                 input ex_pkg::word_t a, input ex_pkg::word_t b,
                                 output ex_pkg::wb_t wb, output ex_pkg::jump_t jmp);
    logic [2:0] f3;
    logic [6:0] f7;
    ex_pkg::word_t imm_i, imm_b, imm_u, imm_j;
    f3 = ins[14:12];
    f7 = ins[31:25];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'h000};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    wb = '0;
    wb.rd_addr = ins[11:7];
    jmp = '0;
    case (ins[6:0])
        `OPC_OP_IMM: begin
            if (!(f3 == `F3_SLL && f7 != `F7_BASE) &&
                !(f3 == `F3_SR && f7 != `F7_BASE && f7 != `F7_ALT)) begin
                wb.wr_en   = 1'b1;
                wb.rd_data = alu_ref(f3, f3 == `F3_SR && f7 == `F7_ALT, a, imm_i);
            end
        end
        `OPC_OP: begin
            if (f7 == `F7_MULDIV) begin
                wb.wr_en   = f3[2];  // no multiply
                wb.rd_data = div_ref(f3, a, b);
            end else if (f7 == `F7_BASE ||
                         (f7 == `F7_ALT && (f3 == `F3_ADD_SUB || f3 == `F3_SR))) begin
                wb.wr_en   = 1'b1;
                wb.rd_data = alu_ref(f3, f7 == `F7_ALT, a, b);
            end
        end
        `OPC_LUI: begin
            wb.wr_en   = 1'b1;
            wb.rd_data = imm_u;
        end
        `OPC_AUIPC: begin
            wb.wr_en   = 1'b1;
            wb.rd_data = pc + imm_u;
        end
        `OPC_BRANCH: begin
            case (f3)
                `F3_BEQ:  jmp.en = (a == b);
                `F3_BNE:  jmp.en = (a != b);
                `F3_BLT:  jmp.en = ($signed(a) < $signed(b));
                `F3_BGE:  jmp.en = ($signed(a) >= $signed(b));
                `F3_BLTU: jmp.en = (a < b);
                `F3_BGEU: jmp.en = (a >= b);
                default:  jmp.en = 1'b0;
            endcase
            jmp.addr = pc + imm_b;
        end
        `OPC_JAL: begin
            wb.wr_en   = 1'b1;
            wb.rd_data = pc + 32'd4;
            jmp.en     = 1'b1;
            jmp.addr   = pc + imm_j;
        end
        `OPC_JALR: begin
            if (f3 == `F3_JALR) begin
                wb.wr_en   = 1'b1;
                wb.rd_data = pc + 32'd4;
                jmp.en     = 1'b1;
                jmp.addr   = (a + imm_i) & ~32'h1;
            end
        end
        default: wb.wr_en = 1'b0;
    endcase
endfunction

`endif

// ==== tb/ex_tb.sv ====
`timescale 1ns/1ns
`include "ex_consts.svh"

module ex_tb;

    logic          clk;
    logic          rst;
    ex_pkg::word_t ins, pc, rs1, rs2;
    ex_pkg::wb_t   wb;
    ex_pkg::jump_t jump;
    logic          hold;

    string         exp_name;  // handed to the compare process
    logic          exp_hold;
    ex_pkg::wb_t   exp_wb;
    ex_pkg::jump_t exp_jump;
    event          compare_ev;
    integer        seed;

    `include "ex_tb_ref.svh"

    ex_stage UUT (
        .clk        (clk),
        .rst        (rst),
        .ins_i      (ins),
        .ins_addr_i (pc),
        .rs1_data_i (rs1),
        .rs2_data_i (rs2),
        .wb_o       (wb),
        .jump_o     (jump),
        .hold_o     (hold)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_hold(input string name, input logic e, input logic a);
        if (a !== e)
            stop_fail($sformatf("ERROR %s: hold expected %b actual %b", name, e, a));
    endtask

    // data and address only matter when enabled
    task automatic check_wb(input string name, input ex_pkg::wb_t e, input ex_pkg::wb_t a);
        if (a.wr_en !== e.wr_en ||
            (e.wr_en && (a.rd_addr !== e.rd_addr || a.rd_data !== e.rd_data)))
            stop_fail($sformatf("ERROR %s: wb expected x%0d=%h we=%b actual x%0d=%h we=%b",
                name, e.rd_addr, e.rd_data, e.wr_en, a.rd_addr, a.rd_data, a.wr_en));
    endtask

    task automatic check_jump(input string name, input ex_pkg::jump_t e, input ex_pkg::jump_t a);
        if (a.en !== e.en || (e.en && a.addr !== e.addr))
            stop_fail($sformatf("ERROR %s: jump expected %h en=%b actual %h en=%b",
                name, e.addr, e.en, a.addr, a.en));
    endtask

    always @(compare_ev) begin
        check_hold(exp_name, exp_hold, hold);
        check_wb(exp_name, exp_wb, wb);
        check_jump(exp_name, exp_jump, jump);
    end

    task automatic sample_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic request_compare(input string name, input logic h,
                                   input ex_pkg::wb_t w, input ex_pkg::jump_t j);
        exp_name = name;
        exp_hold = h;
        exp_wb   = w;
        exp_jump = j;
        -> compare_ev;
    endtask

    task automatic apply(input ex_pkg::word_t i, p, a, b);
        @(negedge clk);
        ins = i;
        pc  = p;
        rs1 = a;
        rs2 = b;
    endtask

    task automatic run_single(input string name, input ex_pkg::word_t i, p, a, b);
        ex_pkg::wb_t   ew;
        ex_pkg::jump_t ej;
        apply(i, p, a, b);
        ref_exec(i, p, a, b, ew, ej);
        sample_cycle();
        request_compare(name, 1'b0, ew, ej);
    endtask

    task automatic run_div(input string name, input ex_pkg::word_t i, p, a, b);
        ex_pkg::wb_t   ew;
        ex_pkg::jump_t ej;
        int            cycles;
        apply(i, p, a, b);
        ref_exec(i, p, a, b, ew, ej);
        sample_cycle();
        request_compare(name, 1'b1, '0, '0);  // held from the first cycle
        cycles = 0;
        sample_cycle();
        while (hold) begin
            request_compare(name, 1'b1, '0, '0);
            cycles++;
            if (cycles >= 100)
                stop_fail($sformatf("timeout: %s kept hold high for 100 cycles", name));
            sample_cycle();
        end
        request_compare(name, 1'b0, ew, ej);
    endtask

    initial begin : stimulus
        ex_pkg::word_t w, a, b;
        logic [6:0]    f7;
        int            k;
        int            m;
        seed = 68005;
        rst = 1'b1;
        ins = '0;
        pc  = '0;
        rs1 = '0;
        rs2 = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        run_single("after_reset", '0, '0, '0, '0);

        for (k = 0; k < 200; k++) begin
            w = $random(seed);
            m = $random(seed) & 7;
            f7 = $random(seed);
            if (m < 4)
                f7 = `F7_BASE;
            else if (m < 6)
                f7 = `F7_ALT;
            if (f7 == `F7_MULDIV)
                f7 = 7'h41;  // bad func7, not a divide
            w[31:25] = f7;
            w[6:0] = (k % 2) ? `OPC_OP : `OPC_OP_IMM;
            run_single($sformatf("alu_%0d", k), w, $random(seed), $random(seed), $random(seed));
        end

        for (k = 0; k < 80; k++) begin
            w = $random(seed);
            case (k % 4)
                0: w[6:0] = `OPC_LUI;
                1: w[6:0] = `OPC_AUIPC;
                2: w[6:0] = `OPC_JAL;
                default: begin
                    w[6:0] = `OPC_JALR;
                    if (k % 8 != 3)
                        w[14:12] = `F3_JALR;
                end
            endcase
            run_single($sformatf("upper_jump_%0d", k), w, $random(seed), $random(seed),
                       $random(seed));
        end

        // random, equal and sign-differing operands
        for (k = 0; k < 160; k++) begin
            w = $random(seed);
            w[14:12] = 3'(k);
            w[6:0] = `OPC_BRANCH;
            a = $random(seed);
            b = $random(seed);
            m = (k / 8) % 4;
            if (m == 1)
                b = a;
            else if (m >= 2) begin
                a[31] = (m == 2);
                b[31] = (m == 3);
            end
            run_single($sformatf("branch_%0d", k), w, $random(seed), a, b);
        end

        for (k = 0; k < 96; k++) begin
            w = $random(seed);
            w[31:25] = `F7_MULDIV;
            w[14:12] = 3'(4 + k % 4);
            w[6:0] = `OPC_OP;
            a = $random(seed);
            b = $random(seed);
            m = (k / 4) % 6;
            if (m == 0)
                b = '0;
            else if (m == 1) begin
                a = 32'h8000_0000;
                b = 32'hffff_ffff;
            end else if (m == 2)
                b = {24'h0, b[7:0]};
            else if (m == 3)
                b = -{24'h0, b[7:0]};
            run_div($sformatf("div_%0d", k), w, $random(seed), a, b);
        end

        for (k = 0; k < 8; k++) begin
            w = {`F7_MULDIV, 10'h0a1, 3'(4 + k % 4), 5'd7, `OPC_OP};
            run_div($sformatf("b2b_first_%0d", k), w, $random(seed), $random(seed),
                    {24'h0, 8'(3 + k)});
            w[14:12] = 3'(4 + (k + 1) % 4);
            w[11:7] = 5'd9;
            run_div($sformatf("b2b_second_%0d", k), w, $random(seed), $random(seed),
                    -32'(5 + k));
        end

        @(negedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== verilog/ex_stage.sv ====
`timescale 1ns/1ns

module ex_stage (
    input  logic          clk,
    input  logic          rst,
    input  ex_pkg::word_t ins_i,
    input  ex_pkg::word_t ins_addr_i,
    input  ex_pkg::word_t rs1_data_i,
    input  ex_pkg::word_t rs2_data_i,
    output ex_pkg::wb_t   wb_o,
    output ex_pkg::jump_t jump_o,
    output logic          hold_o
);

    ex_pkg::ctrl_t      ctrl;
    ex_pkg::word_t      op_a, op_b, alu_result;
    ex_pkg::alu_flags_t flags;
    ex_pkg::word_t      div_a, div_b, div_result;
    logic               div_req, div_done;

    ex_decode u_decode (
        .ins_i      (ins_i),
        .ins_addr_i (ins_addr_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .ctrl_o     (ctrl),
        .op_a_o     (op_a),
        .op_b_o     (op_b),
        .div_req_o  (div_req),
        .div_a_o    (div_a),
        .div_b_o    (div_b)
    );

    ex_alu u_alu (
        .op_i     (ctrl.alu_op),
        .a_i      (op_a),
        .b_i      (op_b),
        .result_o (alu_result),
        .flags_o  (flags)
    );

    ex_div u_div (
        .clk        (clk),
        .rst        (rst),
        .req_i      (div_req),
        .op_i       (ctrl.div_op),
        .dividend_i (div_a),
        .divisor_i  (div_b),
        .result_o   (div_result),
        .done_o     (div_done)
    );

    ex_writeback u_writeback (
        .ctrl_i       (ctrl),
        .alu_result_i (alu_result),
        .flags_i      (flags),
        .div_result_i (div_result),
        .div_done_i   (div_done),
        .wb_o         (wb_o),
        .jump_o       (jump_o),
        .hold_o       (hold_o)
    );

endmodule

// ==== verilog/ex_writeback.sv ====
`timescale 1ns/1ns

module ex_writeback (
    input  ex_pkg::ctrl_t      ctrl_i,
    input  ex_pkg::word_t      alu_result_i,
    input  ex_pkg::alu_flags_t flags_i,
    input  ex_pkg::word_t      div_result_i,
    input  logic               div_done_i,
    output ex_pkg::wb_t        wb_o,
    output ex_pkg::jump_t      jump_o,
    output logic               hold_o
);

    logic taken;

    always_comb begin
        wb_o.rd_addr = ctrl_i.rd;
        case (ctrl_i.res_sel)
            ex_pkg::RES_ALU: begin
                wb_o.rd_data = alu_result_i;
                wb_o.wr_en   = 1'b1;
            end
            ex_pkg::RES_IMM: begin
                wb_o.rd_data = ctrl_i.imm;
                wb_o.wr_en   = 1'b1;
            end
            ex_pkg::RES_LINK: begin
                wb_o.rd_data = ctrl_i.link;
                wb_o.wr_en   = 1'b1;
            end
            ex_pkg::RES_DIV: begin
                wb_o.rd_data = div_result_i;
                wb_o.wr_en   = div_done_i;  // only in the completion cycle
            end
            default: begin
                wb_o.rd_data = '0;
                wb_o.wr_en   = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (ctrl_i.br_cond)
            ex_pkg::BR_EQ:  taken = flags_i.eq;
            ex_pkg::BR_NE:  taken = !flags_i.eq;
            ex_pkg::BR_LT:  taken = flags_i.lt;
            ex_pkg::BR_GE:  taken = !flags_i.lt;
            ex_pkg::BR_LTU: taken = flags_i.ltu;
            ex_pkg::BR_GEU: taken = !flags_i.ltu;
            default:        taken = 1'b0;
        endcase
    end

    assign jump_o.en   = ctrl_i.is_jump || (ctrl_i.is_branch && taken);
    assign jump_o.addr = jump_o.en ? ctrl_i.target : '0;

    // stall the pipe until the divider reports
    assign hold_o = (ctrl_i.res_sel == ex_pkg::RES_DIV) && !div_done_i;

endmodule

// ==== verilog/ex_div.sv ====
`timescale 1ns/1ns
`include "ex_consts.svh"

module ex_div (
    input  logic            clk,
    input  logic            rst,
    input  logic            req_i,
    input  ex_pkg::div_op_e op_i,
    input  ex_pkg::word_t   dividend_i,
    input  ex_pkg::word_t   divisor_i,
    output ex_pkg::word_t   result_o,
    output logic            done_o
);

    localparam int CNT_W = $clog2(`XLEN);

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} state_e;

    state_e state;
    logic [CNT_W-1:0] cnt;
    ex_pkg::div_op_e op_q;
    ex_pkg::word_t quot_q, rem_q, dvs_q;
    logic neg_quot_q, neg_rem_q, zero_q, ovf_q;
    logic is_signed, start;
    ex_pkg::word_t abs_a, abs_b, quot_fix, rem_fix;
    logic [`XLEN:0] trial, diff;

    assign is_signed = (op_i == ex_pkg::DIV_DIV) || (op_i == ex_pkg::DIV_REM);
    assign abs_a = (is_signed && dividend_i[`XLEN-1]) ? -dividend_i : dividend_i;
    assign abs_b = (is_signed && divisor_i[`XLEN-1]) ? -divisor_i : divisor_i;
    assign start = req_i && (state == S_IDLE);  // no restart while done

    // restoring step on the partial remainder
    assign trial = {rem_q, quot_q[`XLEN-1]};
    assign diff  = trial - {1'b0, dvs_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    cnt <= '0;
                    if (start)
                        state <= S_RUN;
                end
                S_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`XLEN-1))
                        state <= S_DONE;
                end
                default: state <= S_IDLE;  // done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quot_q     <= abs_a;
            rem_q      <= '0;
            dvs_q      <= abs_b;
            op_q       <= op_i;
            neg_quot_q <= is_signed && (dividend_i[`XLEN-1] ^ divisor_i[`XLEN-1]);
            neg_rem_q  <= is_signed && dividend_i[`XLEN-1];
            zero_q     <= (divisor_i == '0);
            ovf_q      <= is_signed && (dividend_i == {1'b1, {(`XLEN-1){1'b0}}}) &&
                          (divisor_i == '1);
        end else if (state == S_RUN) begin
            if (!diff[`XLEN]) begin
                rem_q  <= diff[`XLEN-1:0];
                quot_q <= {quot_q[`XLEN-2:0], 1'b1};
            end else begin
                rem_q  <= trial[`XLEN-1:0];
                quot_q <= {quot_q[`XLEN-2:0], 1'b0};
            end
        end
    end

    always_comb begin
        quot_fix = neg_quot_q ? -quot_q : quot_q;
        rem_fix  = neg_rem_q ? -rem_q : rem_q;  // remainder takes dividend sign
        if (zero_q)
            quot_fix = '1;
        if (ovf_q) begin
            quot_fix = {1'b1, {(`XLEN-1){1'b0}}};
            rem_fix  = '0;
        end
        if (op_q == ex_pkg::DIV_REM || op_q == ex_pkg::DIV_REMU)
            result_o = rem_fix;
        else
            result_o = quot_fix;
    end

    assign done_o = (state == S_DONE);

endmodule

// ==== verilog/ex_decode.sv ====
`timescale 1ns/1ns
`include "ex_consts.svh"

module ex_decode (
    input  ex_pkg::word_t ins_i,
    input  ex_pkg::word_t ins_addr_i,
    input  ex_pkg::word_t rs1_data_i,
    input  ex_pkg::word_t rs2_data_i,
    output ex_pkg::ctrl_t ctrl_o,
    output ex_pkg::word_t op_a_o,
    output ex_pkg::word_t op_b_o,
    output logic          div_req_o,
    output ex_pkg::word_t div_a_o,
    output ex_pkg::word_t div_b_o
);

    ex_pkg::opcode_e opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    ex_pkg::word_t imm_i, imm_b, imm_u, imm_j;
    ex_pkg::word_t addr_base, addr_offset, addr_sum, link_addr;

    function automatic ex_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            `F3_ADD_SUB: alu_sel = alt ? ex_pkg::ALU_SUB : ex_pkg::ALU_ADD;
            `F3_SLL:     alu_sel = ex_pkg::ALU_SLL;
            `F3_SLT:     alu_sel = ex_pkg::ALU_SLT;
            `F3_SLTU:    alu_sel = ex_pkg::ALU_SLTU;
            `F3_XOR:     alu_sel = ex_pkg::ALU_XOR;
            `F3_SR:      alu_sel = alt ? ex_pkg::ALU_SRA : ex_pkg::ALU_SRL;
            `F3_OR:      alu_sel = ex_pkg::ALU_OR;
            default:     alu_sel = ex_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode = ex_pkg::opcode_e'(ins_i[6:0]);
    assign func3  = ins_i[14:12];
    assign func7  = ins_i[31:25];

    assign imm_i = {{(`XLEN-11){ins_i[31]}}, ins_i[30:20]};
    assign imm_b = {{(`XLEN-12){ins_i[31]}}, ins_i[7], ins_i[30:25], ins_i[11:8], 1'b0};
    assign imm_u = {ins_i[31:12], 12'h000};
    assign imm_j = {{(`XLEN-20){ins_i[31]}}, ins_i[19:12], ins_i[20], ins_i[30:21], 1'b0};

    // one adder for auipc, branch, jal and jalr
    always_comb begin
        addr_base   = ins_addr_i;
        addr_offset = imm_b;
        case (opcode)
            ex_pkg::AUIPC: addr_offset = imm_u;
            ex_pkg::JAL:   addr_offset = imm_j;
            ex_pkg::JALR: begin
                addr_base   = rs1_data_i;
                addr_offset = imm_i;
            end
            default: addr_offset = imm_b;
        endcase
    end

    assign addr_sum  = addr_base + addr_offset;
    assign link_addr = ins_addr_i + `XLEN'(4);

    assign div_a_o = rs1_data_i;
    assign div_b_o = rs2_data_i;

    always_comb begin
        ctrl_o         = '0;
        ctrl_o.res_sel = ex_pkg::RES_NONE;  // unknown encodings stay here
        ctrl_o.alu_op  = alu_sel(func3, 1'b0);
        ctrl_o.br_cond = ex_pkg::branch_e'(func3);
        ctrl_o.div_op  = ex_pkg::div_op_e'(func3[1:0]);
        ctrl_o.rd      = ins_i[11:7];
        ctrl_o.imm     = imm_u;
        ctrl_o.link    = link_addr;
        ctrl_o.target  = addr_sum;
        op_a_o         = rs1_data_i;
        op_b_o         = rs2_data_i;
        div_req_o      = 1'b0;
        case (opcode)
            ex_pkg::OP_IMM: begin
                op_b_o        = imm_i;
                ctrl_o.alu_op = alu_sel(func3, func7[5] && func3 == `F3_SR);
                if (!((func3 == `F3_SLL && func7 != `F7_BASE) ||
                      (func3 == `F3_SR && func7 != `F7_BASE && func7 != `F7_ALT)))
                    ctrl_o.res_sel = ex_pkg::RES_ALU;
            end
            ex_pkg::OP: begin
                ctrl_o.alu_op = alu_sel(func3, func7[5]);
                if (func7 == `F7_MULDIV) begin
                    if (func3[2]) begin  // multiply half is not supported
                        ctrl_o.res_sel = ex_pkg::RES_DIV;
                        div_req_o      = 1'b1;
                    end
                end else if (func7 == `F7_BASE ||
                             (func7 == `F7_ALT && (func3 == `F3_ADD_SUB || func3 == `F3_SR)))
                    ctrl_o.res_sel = ex_pkg::RES_ALU;
            end
            ex_pkg::LUI: ctrl_o.res_sel = ex_pkg::RES_IMM;
            ex_pkg::AUIPC: begin
                ctrl_o.res_sel = ex_pkg::RES_IMM;
                ctrl_o.imm     = addr_sum;
            end
            ex_pkg::BRANCH: ctrl_o.is_branch = (func3 != 3'b010) && (func3 != 3'b011);
            ex_pkg::JAL: begin
                ctrl_o.res_sel = ex_pkg::RES_LINK;
                ctrl_o.is_jump = 1'b1;
            end
            ex_pkg::JALR: begin
                if (func3 == `F3_JALR) begin
                    ctrl_o.res_sel = ex_pkg::RES_LINK;
                    ctrl_o.is_jump = 1'b1;
                end
                ctrl_o.target = {addr_sum[`XLEN-1:1], 1'b0};  // lsb cleared
            end
            default: ctrl_o.res_sel = ex_pkg::RES_NONE;
        endcase
    end

endmodule

// ==== verilog/ex_alu.sv ====
`timescale 1ns/1ns
`include "ex_consts.svh"

module ex_alu (
    input  ex_pkg::alu_op_e    op_i,
    input  ex_pkg::word_t      a_i,
    input  ex_pkg::word_t      b_i,
    output ex_pkg::word_t      result_o,
    output ex_pkg::alu_flags_t flags_o
);

    localparam int SH_W = $clog2(`XLEN);

    logic [SH_W-1:0] shamt;

    assign shamt = b_i[SH_W-1:0];

    // compare flags serve slt/sltu and branch resolution
    assign flags_o.eq  = (a_i == b_i);
    assign flags_o.lt  = ($signed(a_i) < $signed(b_i));
    assign flags_o.ltu = (a_i < b_i);

    always_comb begin
        case (op_i)
            ex_pkg::ALU_ADD:  result_o = a_i + b_i;
            ex_pkg::ALU_SUB:  result_o = a_i - b_i;
            ex_pkg::ALU_AND:  result_o = a_i & b_i;
            ex_pkg::ALU_OR:   result_o = a_i | b_i;
            ex_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            ex_pkg::ALU_SLT:  result_o = {{(`XLEN-1){1'b0}}, flags_o.lt};
            ex_pkg::ALU_SLTU: result_o = {{(`XLEN-1){1'b0}}, flags_o.ltu};
            ex_pkg::ALU_SLL:  result_o = a_i << shamt;
            ex_pkg::ALU_SRL:  result_o = a_i >> shamt;
            ex_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
            default:          result_o = '0;
        endcase
    end

endmodule

// ==== verilog/ex_pkg.sv ====
`include "ex_consts.svh"

package ex_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`RLEN-1:0] reg_addr_t;

    typedef enum logic [6:0] {
        OP_IMM = `OPC_OP_IMM,
        OP     = `OPC_OP,
        LUI    = `OPC_LUI,
        AUIPC  = `OPC_AUIPC,
        BRANCH = `OPC_BRANCH,
        JAL    = `OPC_JAL,
        JALR   = `OPC_JALR
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_EQ  = `F3_BEQ,
        BR_NE  = `F3_BNE,
        BR_LT  = `F3_BLT,
        BR_GE  = `F3_BGE,
        BR_LTU = `F3_BLTU,
        BR_GEU = `F3_BGEU
    } branch_e;

    // low two bits of the divide func3
    typedef enum logic [1:0] {
        DIV_DIV  = 2'(`F3_DIV),
        DIV_DIVU = 2'(`F3_DIVU),
        DIV_REM  = 2'(`F3_REM),
        DIV_REMU = 2'(`F3_REMU)
    } div_op_e;

    typedef enum logic [2:0] {
        RES_NONE, RES_ALU, RES_IMM, RES_LINK, RES_DIV
    } res_sel_e;

    typedef struct packed {
        res_sel_e  res_sel;
        alu_op_e   alu_op;
        logic      is_branch;
        branch_e   br_cond;
        logic      is_jump;
        div_op_e   div_op;
        reg_addr_t rd;
        word_t     imm;     // lui value or auipc sum
        word_t     link;    // pc+4
        word_t     target;
    } ctrl_t;

    typedef struct packed {
        logic eq;
        logic lt;
        logic ltu;
    } alu_flags_t;

    typedef struct packed {
        reg_addr_t rd_addr;
        word_t     rd_data;
        logic      wr_en;
    } wb_t;

    typedef struct packed {
        word_t addr;
        logic  en;
    } jump_t;

endpackage

// ==== verilog/ex_consts.svh ====
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

`define XLEN 32
`define RLEN 5

// major opcodes
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111

// op and op-imm func3
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// branch func3
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

// divide group func3, with func7 = muldiv
`define F3_DIV      3'b100
`define F3_DIVU     3'b101
`define F3_REM      3'b110
`define F3_REMU     3'b111

`define F3_JALR     3'b000

`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000  // sub, sra, srai
`define F7_MULDIV   7'b0000001

`endif
